// File: rtl/wb_map_pkg.sv
package wb_map_pkg;

  // identification words
  localparam logic [31:0] board_id = 32'h424d_4331;
  localparam logic [31:0] rev_maj  = 32'h0000_0002;
  localparam logic [31:0] rev_min  = 32'h0000_0001;
  localparam logic [31:0] rev_rcs  = 32'h0000_1a2b;

  // word addresses, matched against wb_adr_i[6:2]
  localparam logic [4:0] reg_board_id   = 5'd0;
  localparam logic [4:0] reg_rev_maj    = 5'd1;
  localparam logic [4:0] reg_rev_min    = 5'd2;
  localparam logic [4:0] reg_rev_rcs    = 5'd3;
  localparam logic [4:0] reg_scratch0   = 5'd4;
  localparam logic [4:0] reg_scratch1   = 5'd5;
  localparam logic [4:0] reg_scratch2   = 5'd6;
  localparam logic [4:0] reg_scratch3   = 5'd7;
  localparam logic [4:0] reg_tx_data    = 5'd8;
  localparam logic [4:0] reg_status     = 5'd9;
  localparam logic [4:0] reg_sent_count = 5'd10;

  // status word layout
  localparam int stat_empty_bit = 0;
  localparam int stat_full_bit  = 1;
  localparam int stat_level_lsb = 8;

endpackage

// File: rtl/stream_pkg.sv
package stream_pkg;

  // entries held by the transmit FIFO
  localparam int fifo_depth = 8;

  // fill level needs one bit more than the pointers to show a full FIFO
  localparam int level_w = $clog2(fifo_depth) + 1;

  // one transmit word with the byte select it was written with
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  sel;
  } stream_entry_t;

endpackage

// File: rtl/word_fifo_if.sv
interface word_fifo_if;
  import stream_pkg::*;

  // write side
  logic                push;
  stream_entry_t       push_entry;

  // read side
  logic                pop;
  stream_entry_t       head_entry;

  // status
  logic                full;
  logic                empty;
  logic [level_w-1:0]  level;

  modport producer (
    output push,
    output push_entry,
    input  full,
    input  empty,
    input  level
  );

  modport buffer (
    input  push,
    input  push_entry,
    input  pop,
    output head_entry,
    output full,
    output empty,
    output level
  );

  modport consumer (
    output pop,
    input  empty,
    input  head_entry
  );

endinterface

// File: rtl/sys_regs.sv
module sys_regs (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  output logic [31:0] debug_o,
  input  logic [31:0] sent_count_i,
  word_fifo_if.producer fifo
);
  import wb_map_pkg::*;
  import stream_pkg::*;

  logic [31:0] scratch [4];
  logic [4:0]  reg_addr;
  logic [1:0]  scratch_idx;
  logic        access;
  logic        wr_access;
  logic        scratch_sel;
  logic        tx_sel;
  logic        tx_reject;
  logic [31:0] status_word;

  assign reg_addr = wb_adr_i[6:2];

  // a new access only once the previous response has gone out,
  // so a slow stb drop never produces a second ack or push
  assign access    = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
  assign wr_access = access & wb_we_i;

  assign scratch_sel = (reg_addr >= reg_scratch0) && (reg_addr <= reg_scratch3);
  assign scratch_idx = 2'(reg_addr - reg_scratch0);
  assign tx_sel      = (reg_addr == reg_tx_data);

  // transmit word is dropped when there is no room
  assign tx_reject = wr_access & tx_sel & fifo.full;

  assign fifo.push       = wr_access & tx_sel & ~fifo.full;
  assign fifo.push_entry = '{data: wb_dat_i, sel: wb_sel_i};

  // one-cycle response, err only for a rejected transmit word
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= access & ~tx_reject;
      wb_err_o <= tx_reject;
    end
  end

  // scratchpad with byte enables
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int w = 0; w < 4; w++) begin
        scratch[w] <= '0;
      end
    end else if (wr_access && scratch_sel) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_sel_i[b]) begin
          scratch[scratch_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
        end
      end
    end
  end

  assign debug_o = scratch[0];

  always_comb begin
    status_word = '0;
    status_word[stat_empty_bit] = fifo.empty;
    status_word[stat_full_bit] = fifo.full;
    status_word[stat_level_lsb +: level_w] = fifo.level;
  end

  // read mux, combinational from the address
  always_comb begin
    case (reg_addr)
      reg_board_id:   wb_dat_o = board_id;
      reg_rev_maj:    wb_dat_o = rev_maj;
      reg_rev_min:    wb_dat_o = rev_min;
      reg_rev_rcs:    wb_dat_o = rev_rcs;
      reg_scratch0:   wb_dat_o = scratch[0];
      reg_scratch1:   wb_dat_o = scratch[1];
      reg_scratch2:   wb_dat_o = scratch[2];
      reg_scratch3:   wb_dat_o = scratch[3];
      reg_status:     wb_dat_o = status_word;
      reg_sent_count: wb_dat_o = sent_count_i;
      // tx data is write only
      default:        wb_dat_o = 32'h0;
    endcase
  end

endmodule

// File: rtl/word_fifo.sv
module word_fifo (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  word_fifo_if.buffer fifo
);
  import stream_pkg::*;

  stream_entry_t                     mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0]     wr_ptr;
  logic [$clog2(fifo_depth)-1:0]     rd_ptr;
  logic [level_w-1:0]                level;

  // storage, no reset
  always_ff @(posedge wb_clk_i) begin
    if (fifo.push) begin
      mem[wr_ptr] <= fifo.push_entry;
    end
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (fifo.push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      level <= '0;
    end else begin
      case ({fifo.push, fifo.pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        // push with pop keeps the level
        default: level <= level;
      endcase
    end
  end

  assign fifo.level      = level;
  assign fifo.empty      = (level == '0);
  assign fifo.full       = (level == level_w'(fifo_depth));

  // show-ahead head word
  assign fifo.head_entry = mem[rd_ptr];

endmodule

// File: rtl/stream_drain.sv
module stream_drain (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        out_hold_i,
  output logic        out_valid_o,
  output logic [31:0] out_data_o,
  output logic [31:0] sent_count_o,
  word_fifo_if.consumer fifo
);
  import stream_pkg::*;

  stream_entry_t head;
  logic [31:0]   masked;

  assign head = fifo.head_entry;

  // drain one word per cycle unless held
  assign fifo.pop = ~fifo.empty & ~out_hold_i;

  // unselected bytes go out as zero
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      masked[8*b +: 8] = head.sel[b] ? head.data[8*b +: 8] : 8'h00;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      out_valid_o  <= 1'b0;
      sent_count_o <= '0;
    end else begin
      out_valid_o <= fifo.pop;
      if (fifo.pop) begin
        sent_count_o <= sent_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (fifo.pop) begin
      out_data_o <= masked;
    end
  end

endmodule

// File: rtl/sys_top.sv
module sys_top (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  output logic [31:0] debug_o,
  output logic        out_valid_o,
  output logic [31:0] out_data_o,
  input  logic        out_hold_i
);

  logic [31:0] sent_count;

  word_fifo_if fifo_bus ();

  // host side, pushes transmit words
  sys_regs u_regs (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_sel_i     (wb_sel_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .debug_o      (debug_o),
    .sent_count_i (sent_count),
    .fifo         (fifo_bus.producer)
  );

  word_fifo u_fifo (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .fifo     (fifo_bus.buffer)
  );

  stream_drain u_drain (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .out_hold_i   (out_hold_i),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o),
    .sent_count_o (sent_count),
    .fifo         (fifo_bus.consumer)
  );

endmodule

// File: testbench/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held for 10 cycles, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: testbench/sys_top_chk.sv
module sys_top_chk (
  input logic clk_i,
  input logic rst_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i,
  input logic hold_i,
  input logic empty_i,
  input logic valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
    else $error("ack and err high in the same cycle");

  // response only after a sampled cyc and stb
  resp_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i || err_i) |-> $past(cyc_i && stb_i))
    else $error("bus response without a preceding request");

  // a held cycle with words waiting must not pop
  held_no_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (hold_i && !empty_i) |=> !valid_i)
    else $error("stream output valid after a held cycle");

  resp_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i || err_i) |=> !(ack_i || err_i))
    else $error("bus response longer than one cycle");

endmodule

bind sys_top sys_top_chk u_chk (
  .clk_i   (wb_clk_i),
  .rst_i   (wb_rst_i),
  .cyc_i   (wb_cyc_i),
  .stb_i   (wb_stb_i),
  .ack_i   (wb_ack_o),
  .err_i   (wb_err_o),
  .hold_i  (out_hold_i),
  .empty_i (fifo_bus.empty),
  .valid_i (out_valid_o)
);

// File: testbench/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import wb_map_pkg::*;
  import stream_pkg::*;

  localparam int bus_timeout = 50;
  localparam int drain_timeout = 200;

  logic        wb_clk, wb_rst, wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [3:0]  wb_sel;
  logic [31:0] wb_adr, wb_dat_w, wb_dat_r, debug, out_data;
  logic        out_valid, out_hold;
  logic [31:0] rng_state;
  logic [31:0] exp_q[$];
  logic [31:0] seen_q[$];
  int          seen_total, err_cnt, chk_cnt;

  tb_clk_gen u_clk_gen (.clk_o(wb_clk), .rst_o(wb_rst));

  sys_top uut (
    .wb_clk_i (wb_clk), .wb_rst_i (wb_rst), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
    .wb_we_i (wb_we), .wb_sel_i (wb_sel), .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack), .wb_err_o (wb_err), .debug_o (debug),
    .out_valid_o (out_valid), .out_data_o (out_data), .out_hold_i (out_hold)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // bytes with a clear select bit read as zero
  function automatic logic [31:0] byte_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    chk_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("%0t %s", $time, what);
    end
  endtask

  // one classic cycle, finished on ack or err
  task automatic bus_cycle(input logic we, input logic [4:0] word, input logic [31:0] data,
                           input logic [3:0] sel, output logic [31:0] rdata,
                           output logic got_err);
    int n;
    @(negedge wb_clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_sel = sel;
    wb_adr = {25'd0, word, 2'b00};
    wb_dat_w = data;
    for (n = 0; n < bus_timeout; n++) begin
      @(negedge wb_clk);
      if (wb_ack || wb_err) break;
    end
    check_true(wb_ack || wb_err, "bus cycle got neither ack nor err in time");
    rdata = wb_dat_r;
    got_err = wb_err;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(input logic [4:0] word, input logic [31:0] data,
                          input logic [3:0] sel, output logic got_err);
    logic [31:0] unused;
    bus_cycle(1'b1, word, data, sel, unused, got_err);
  endtask

  task automatic wb_read(input logic [4:0] word, output logic [31:0] data);
    logic got_err;
    bus_cycle(1'b0, word, 32'h0, 4'hf, data, got_err);
    check_eq("wb_err_o", {31'd0, got_err}, 32'd0);
  endtask

  // output monitor
  always @(negedge wb_clk) begin
    if (!wb_rst && out_valid) begin
      seen_q.push_back(out_data);
      seen_total++;
    end
  end

  // waits for all expected words, then compares them in order
  task automatic drain_check();
    logic [31:0] stat;
    int n;
    for (n = 0; n < drain_timeout; n++) begin
      if (seen_q.size() >= exp_q.size()) break;
      @(negedge wb_clk);
    end
    check_true(seen_q.size() >= exp_q.size(), "stream output words missing after timeout");
    wb_read(reg_status, stat);
    check_eq("status", stat, 32'd1 << stat_empty_bit);
    check_eq("stream word count", seen_q.size(), exp_q.size());
    while (exp_q.size() > 0 && seen_q.size() > 0) begin
      check_eq("out_data_o", seen_q.pop_front(), exp_q.pop_front());
    end
    exp_q.delete();
    seen_q.delete();
  endtask

  task automatic test_id_regs();
    logic [31:0] rd;
    wb_read(reg_board_id, rd);
    check_eq("board_id", rd, board_id);
    wb_read(reg_rev_maj, rd);
    check_eq("rev_maj", rd, rev_maj);
    wb_read(reg_rev_min, rd);
    check_eq("rev_min", rd, rev_min);
    wb_read(reg_rev_rcs, rd);
    check_eq("rev_rcs", rd, rev_rcs);
    wb_read(5'd11, rd);
    check_eq("unmapped word 11", rd, 32'h0);
  endtask

  task automatic test_scratch();
    logic [31:0] model [4];
    logic [31:0] data, r, rd;
    logic [3:0]  sel;
    logic [1:0]  idx;
    logic        got_err;
    for (int w = 0; w < 4; w++) model[w] = '0;
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      idx = r[1:0];
      sel = r[7:4];
      data = next_rand();
      wb_write(reg_scratch0 + {3'b0, idx}, data, sel, got_err);
      check_eq("wb_err_o", {31'd0, got_err}, 32'd0);
      model[idx] = (model[idx] & ~byte_mask(sel)) | (data & byte_mask(sel));
      for (int w = 0; w < 4; w++) begin
        wb_read(reg_scratch0 + 5'(w), rd);
        check_eq("scratch", rd, model[w]);
      end
      check_eq("debug_o", debug, model[0]);
    end
  endtask

  task automatic test_stream();
    logic [31:0] data, r;
    logic        got_err;
    for (int i = 0; i < 5; i++) begin
      data = next_rand();
      r = next_rand();
      wb_write(reg_tx_data, data, r[3:0], got_err);
      check_eq("wb_err_o", {31'd0, got_err}, 32'd0);
      exp_q.push_back(data & byte_mask(r[3:0]));
      // word leaves one edge after the response
      @(negedge wb_clk);
      check_eq("out_valid_o", {31'd0, out_valid}, 32'd1);
      check_eq("out_data_o", out_data, data & byte_mask(r[3:0]));
    end
    drain_check();
  endtask

  task automatic test_backpressure();
    logic [31:0] data, r, stat, exp_stat;
    logic        got_err;
    int          seen_before;
    @(negedge wb_clk);
    out_hold = 1'b1;
    seen_before = seen_total;
    for (int i = 0; i <= fifo_depth; i++) begin
      data = next_rand();
      r = next_rand();
      wb_write(reg_tx_data, data, r[3:0], got_err);
      check_eq("wb_err_o", {31'd0, got_err}, (i == fifo_depth) ? 32'd1 : 32'd0);
      if (i < fifo_depth) exp_q.push_back(data & byte_mask(r[3:0]));
    end
    exp_stat = '0;
    exp_stat[stat_full_bit] = 1'b1;
    exp_stat[stat_level_lsb +: level_w] = level_w'(fifo_depth);
    wb_read(reg_status, stat);
    check_eq("status", stat, exp_stat);
    check_true(seen_total == seen_before, "stream output moved while hold was high");
    @(negedge wb_clk);
    out_hold = 1'b0;
    drain_check();
  endtask

  task automatic test_sent_count();
    logic [31:0] rd;
    wb_read(reg_sent_count, rd);
    check_eq("sent_count", rd, seen_total);
  endtask

  initial begin
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_sel = 4'h0;
    wb_adr = 32'h0;
    wb_dat_w = 32'h0;
    out_hold = 1'b0;
    rng_state = 32'h3c26;
    seen_total = 0;
    err_cnt = 0;
    chk_cnt = 0;
    for (int n = 0; n < 100; n++) begin
      @(negedge wb_clk);
      if (!wb_rst) break;
    end
    check_true(!wb_rst, "reset was never released");
    test_id_regs();
    test_scratch();
    test_stream();
    test_backpressure();
    test_sent_count();
    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sys_top.f
rtl/wb_map_pkg.sv
rtl/stream_pkg.sv
rtl/word_fifo_if.sv
rtl/sys_regs.sv
rtl/word_fifo.sv
rtl/stream_drain.sv
rtl/sys_top.sv
testbench/tb_clk_gen.sv
testbench/sys_top_chk.sv
testbench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, decide by the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sys_top.f &&
{ ./obj_dir/Vtb_top > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "test passed" sim.log ||
{ echo "simulation did not pass, see sim.log"; exit 1; }
